// File: rtl/ahbRamCtrl.sv
// AHB-Lite slave FSM with address capture, wait sequencing, HREADYOUT and write strobe

`timescale 1ns/10ps

module ahbRamCtrl #(
  parameter int DataWidth = 32
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  HSEL,
  input  ahbRamPkg::addrT       HADDR,
  input  logic                  HWRITE,
  input  ahbRamPkg::transT      HTRANS,
  input  ahbRamPkg::sizeT       HSIZE,
  input  logic [DataWidth-1:0]  HWDATA,
  input  logic                  HREADY,
  input  logic                  waitDone,
  output logic [DataWidth-1:0]  HRDATA,
  output logic                  HREADYOUT,
  output logic                  waitStart,
  ramAccessIf.ctrl              mem
);

  // Address bits below the word index
  localparam int OffsetBits = $clog2(DataWidth / 8);

  // Idle has no transfer, Wait stretches the data phase, Complete ends it
  typedef enum logic [1:0] {
    Idle,
    Wait,
    Complete
  } stateT;

  stateT                state;
  stateT                nextState;
  ahbRamPkg::addrT      addrQ;
  ahbRamPkg::sizeT      sizeQ;
  logic                 writeQ;
  logic [DataWidth-1:0] readHold;
  logic                 activeTrans;
  logic                 accept;
  logic                 readDone;

  //////////////////////////////////////////////////////////////////////
  // Address phase
  //////////////////////////////////////////////////////////////////////

  // SEQ is handled exactly like NONSEQ, bursts need nothing extra here
  assign activeTrans = (HTRANS == ahbRamPkg::TransNonseq) ||
                       (HTRANS == ahbRamPkg::TransSeq);

  // No address phase can complete while this slave holds the bus in Wait
  assign accept    = HSEL & HREADY & activeTrans & (state != Wait);
  // The counter restarts on the same edge that captures the address
  assign waitStart = accept;

  // Address and size are plain payload and only load on acceptance
  always_ff @(posedge HCLK) begin
    if (accept) begin
      addrQ <= HADDR;
      sizeQ <= HSIZE;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      writeQ <= 1'b0;
    end else if (accept) begin
      writeQ <= HWRITE;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      Idle: begin
        if (accept) begin
          nextState = Wait;
        end
      end
      // The counter holds done high once the wait states have run out
      Wait: begin
        if (waitDone) begin
          nextState = Complete;
        end
      end
      // A transfer accepted here overlaps this ending cycle with no gap
      Complete: begin
        nextState = accept ? Wait : Idle;
      end
      default: begin
        nextState = Idle;
      end
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

  // Ready is low only in Wait, which makes it high out of reset
  assign HREADYOUT = (state != Wait);

  //////////////////////////////////////////////////////////////////////
  // Data phase
  //////////////////////////////////////////////////////////////////////

  // The array writes on the edge that closes Complete, with HWDATA valid then
  assign mem.writeEn    = (state == Complete) & writeQ;
  assign mem.wdata      = HWDATA;
  assign mem.size       = sizeQ;
  assign mem.byteOffset = addrQ[OffsetBits-1:0];
  // Dropping the upper bits wraps the address modulo the memory depth
  assign mem.wordAddr   = addrQ[OffsetBits +: $bits(mem.wordAddr)];

  assign readDone = (state == Complete) & ~writeQ;

  // Keep the last read word so HRDATA stays put between reads
  always_ff @(posedge HCLK) begin
    if (readDone) begin
      readHold <= mem.rdata;
    end
  end

  assign HRDATA = readDone ? mem.rdata : readHold;

endmodule

// File: rtl/ahbRamPkg.sv
// Bus field types, wait-count type and the HTRANS and HSIZE codes of the AHB RAM

package ahbRamPkg;

  //////////////////////////////////////////////////////////////////////
  // Field types
  //////////////////////////////////////////////////////////////////////

  // Byte address as seen on HADDR
  typedef logic [31:0] addrT;

  // Transfer size field, log2 of the number of bytes moved
  typedef logic [2:0] sizeT;

  // Transfer type field
  typedef logic [1:0] transT;

  // Number of extra cycles a data phase is stretched by
  typedef logic [3:0] waitT;

  //////////////////////////////////////////////////////////////////////
  // HTRANS codes
  //////////////////////////////////////////////////////////////////////

  // Only NONSEQ and SEQ start a transfer, IDLE and BUSY are ignored
  localparam transT TransIdle   = 2'b00;
  localparam transT TransBusy   = 2'b01;
  localparam transT TransNonseq = 2'b10;
  localparam transT TransSeq    = 2'b11;

  //////////////////////////////////////////////////////////////////////
  // HSIZE codes
  //////////////////////////////////////////////////////////////////////

  // Sizes above a doubleword are legal on the bus and act as a full word here
  localparam sizeT SizeByte   = 3'b000;
  localparam sizeT SizeHalf   = 3'b001;
  localparam sizeT SizeWord   = 3'b010;
  localparam sizeT SizeDouble = 3'b011;

endpackage

// File: rtl/ahbRamTop.sv
// AHB-Lite RAM slave top connecting controller, wait counter and memory array

`timescale 1ns/10ps

module ahbRamTop #(
  parameter int DataWidth  = 32,
  parameter int MemWords   = 1024,
  parameter int WaitStates = 2
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  HSEL,
  input  ahbRamPkg::addrT       HADDR,
  input  logic                  HWRITE,
  input  ahbRamPkg::transT      HTRANS,
  input  ahbRamPkg::sizeT       HSIZE,
  input  logic [DataWidth-1:0]  HWDATA,
  input  logic                  HREADY,
  output logic [DataWidth-1:0]  HRDATA,
  output logic                  HREADYOUT
);

  // Handshake between the FSM and the wait counter
  logic waitStart;
  logic waitDone;

  // Captured access from the controller to the array
  ramAccessIf #(
    .DataWidth (DataWidth),
    .MemWords  (MemWords)
  ) ramAcc ();

  ahbRamCtrl #(
    .DataWidth (DataWidth)
  ) i_ahbRamCtrl (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWRITE    (HWRITE),
    .HTRANS    (HTRANS),
    .HSIZE     (HSIZE),
    .HWDATA    (HWDATA),
    .HREADY    (HREADY),
    .waitDone  (waitDone),
    .HRDATA    (HRDATA),
    .HREADYOUT (HREADYOUT),
    .waitStart (waitStart),
    .mem       (ramAcc.ctrl)
  );

  // The only place the wait length is set
  waitCounter #(
    .WaitStates (WaitStates)
  ) i_waitCounter (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .start   (waitStart),
    .done    (waitDone)
  );

  ramArray #(
    .DataWidth (DataWidth),
    .MemWords  (MemWords)
  ) i_ramArray (
    .HCLK (HCLK),
    .acc  (ramAcc.mem)
  );

endmodule

// File: rtl/byteLaneMask.sv
// Byte-lane write mask decoder from transfer size and address offset

`timescale 1ns/10ps

module byteLaneMask #(
  parameter int DataWidth = 32
) (
  input  ahbRamPkg::sizeT              size,
  input  logic [$clog2(DataWidth/8)-1:0] byteOffset,
  output logic [DataWidth/8-1:0]         mask
);

  localparam int Lanes      = DataWidth / 8;
  localparam int OffsetBits = $clog2(Lanes);

  // Lanes of the transfer when placed at offset zero
  logic [Lanes-1:0]      baseMask;
  // Offset bits kept after aligning down to the transfer size
  logic [OffsetBits-1:0] alignMask;

  always_comb begin
    // Anything as wide as the word or wider writes every lane
    baseMask  = '1;
    alignMask = '0;
    case (size)
      ahbRamPkg::SizeByte: begin
        baseMask  = Lanes'(1);
        alignMask = '1;
      end
      ahbRamPkg::SizeHalf: begin
        baseMask  = Lanes'(3);
        alignMask = ~OffsetBits'(1);
      end
      // On a 32-bit bus the alignment mask collapses to zero here
      ahbRamPkg::SizeWord: begin
        baseMask  = Lanes'(15);
        alignMask = ~OffsetBits'(3);
      end
      ahbRamPkg::SizeDouble: begin
        baseMask  = Lanes'(255);
        alignMask = ~OffsetBits'(7);
      end
      default: begin
        baseMask  = '1;
        alignMask = '0;
      end
    endcase
    mask = baseMask << (byteOffset & alignMask);
  end

endmodule

// File: rtl/ramAccessIf.sv
// Interface for one captured RAM access, with controller and memory modports

`timescale 1ns/10ps

interface ramAccessIf #(
  parameter int DataWidth = 32,
  parameter int MemWords  = 1024
);

  // Word index width follows the memory depth, so addresses wrap on their own
  localparam int AddrBits   = $clog2(MemWords);
  // Byte position inside one data word
  localparam int OffsetBits = $clog2(DataWidth / 8);

  // Word index of the access, already reduced modulo MemWords
  logic [AddrBits-1:0]   wordAddr;
  // Low address bits that pick the lanes of a sub-word write
  logic [OffsetBits-1:0] byteOffset;
  // Transfer size captured in the address phase
  ahbRamPkg::sizeT       size;
  // High for the single cycle in which the array must take wdata
  logic                  writeEn;
  // Write data straight from HWDATA
  logic [DataWidth-1:0]  wdata;
  // Registered read word from the array
  logic [DataWidth-1:0]  rdata;

  // The controller owns the request side and consumes the read word
  modport ctrl (
    output wordAddr, byteOffset, size, writeEn, wdata,
    input  rdata
  );

  // The array serves the request and returns the read word
  modport mem (
    input  wordAddr, byteOffset, size, writeEn, wdata,
    output rdata
  );

endinterface

// File: rtl/ramArray.sv
// Word-wide RAM with registered read and byte-masked write

`timescale 1ns/10ps

module ramArray #(
  parameter int DataWidth = 32,
  parameter int MemWords  = 1024
) (
  input  logic     HCLK,
  ramAccessIf.mem  acc
);

  localparam int Lanes = DataWidth / 8;

  // Storage, one entry per data word
  logic [DataWidth-1:0] ramWords [MemWords];
  logic [Lanes-1:0]     laneMask;

  //////////////////////////////////////////////////////////////////////
  // Lane selection
  //////////////////////////////////////////////////////////////////////

  byteLaneMask #(
    .DataWidth (DataWidth)
  ) i_byteLaneMask (
    .size       (acc.size),
    .byteOffset (acc.byteOffset),
    .mask       (laneMask)
  );

  //////////////////////////////////////////////////////////////////////
  // Read and write ports
  //////////////////////////////////////////////////////////////////////

  // Read every cycle so the word is ready one cycle after the address
  always_ff @(posedge HCLK) begin
    acc.rdata <= ramWords[acc.wordAddr];
  end

  // One enable per byte lane keeps sub-word writes from touching neighbours
  always_ff @(posedge HCLK) begin
    if (acc.writeEn) begin
      for (int lane = 0; lane < Lanes; lane++) begin
        if (laneMask[lane]) begin
          ramWords[acc.wordAddr][8*lane +: 8] <= acc.wdata[8*lane +: 8];
        end
      end
    end
  end

endmodule

// File: rtl/waitCounter.sv
// Counter that times the wait states of a single data phase

`timescale 1ns/10ps

module waitCounter #(
  parameter int WaitStates = 2
) (
  input  logic HCLK,
  input  logic HRESETn,
  input  logic start,
  output logic done
);

  // Wait count the data phase is stretched by, in the width of the counter
  localparam ahbRamPkg::waitT Target = ahbRamPkg::waitT'(WaitStates);

  ahbRamPkg::waitT count;

  // Start wins over counting, so a back-to-back transfer reloads cleanly
  // and the count parks at the target until the next start
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      count <= '0;
    end else if (start) begin
      count <= '0;
    end else if (!done) begin
      count <= count + ahbRamPkg::waitT'(1);
    end
  end

  // Done follows the edge on which the count reached its target
  // With zero wait states it is already high in the first cycle
  assign done = (count == Target);

endmodule

// File: tb.f
rtl/ahbRamPkg.sv
rtl/ramAccessIf.sv
rtl/waitCounter.sv
rtl/byteLaneMask.sv
rtl/ramArray.sv
rtl/ahbRamCtrl.sv
rtl/ahbRamTop.sv
verif/ahbRamCtrl_assert.sv
verif/ahbRamTb.sv

// File: verif/ahbRamCtrl_assert.sv
// Concurrent assertions on the AHB RAM controller's ready and write strobe, with their bind

`timescale 1ns/10ps

module ahbRamCtrl_assert #(
  parameter int WaitStates = 2
) (
  input logic                   HCLK,
  input logic                   HRESETn,
  input logic                   HSEL,
  input logic                   HREADY,
  input ahbRamPkg::transT       HTRANS,
  input logic                   HREADYOUT,
  input logic                   writeEn
);

  // A transfer is taken when selected, ready and NONSEQ or SEQ
  logic accepted;

  assign accepted = HSEL && HREADY && HTRANS[1] && HREADYOUT;

  // The slave must be ready on the first edge after reset is released
  readyAfterReset: assert property (@(posedge HCLK) $rose(HRESETn) |-> HREADYOUT)
    else $error("HREADYOUT is low right after reset");

  // The array may only be written in the cycle that ends a data phase
  writeOnlyWhenReady: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    writeEn |-> HREADYOUT
  ) else $error("writeEn is high while HREADYOUT is low");

  // Every accepted transfer stretches its data phase by the wait states plus one
  waitLength: assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    accepted |=> !HREADYOUT [*WaitStates+1] ##1 HREADYOUT
  ) else $error("HREADYOUT low time differs from the wait-state count");

endmodule

// Wait-state count of the bench configuration
bind ahbRamCtrl ahbRamCtrl_assert #(
  .WaitStates (2)
) i_ahbRamCtrlAssert (
  .HCLK      (HCLK),
  .HRESETn   (HRESETn),
  .HSEL      (HSEL),
  .HREADY    (HREADY),
  .HTRANS    (HTRANS),
  .HREADYOUT (HREADYOUT),
  .writeEn   (mem.writeEn)
);

// File: verif/ahbRamTb.sv
// Directed testbench for the AHB RAM slave with bus tasks, byte model, checks and watchdog

`timescale 1ns/10ps

module ahbRamTb;

  localparam int DataWidth    = 32;
  localparam int MemWords     = 1024;
  localparam int WaitStates   = 2;
  localparam int BytesPerWord = DataWidth / 8;
  localparam int MemBytes     = MemWords * BytesPerWord;
  // HSIZE code of a full bus word
  localparam int WordSizeCode = $clog2(BytesPerWord);
  localparam int ClkPeriod    = 40;
  localparam int ResetCycles  = 10;
  // A data phase longer than this counts as a hung slave
  localparam int MaxWait      = 32;

  //////////////////////////////////////////////////////////////////////
  // Run length estimate for the watchdog
  //////////////////////////////////////////////////////////////////////

  // One transfer is the accept cycle, the wait states and the ending cycle
  localparam int XferCycles = WaitStates + 3;
  // Reset, word, sub-word, wait-timing and pipeline tests in that order
  localparam int TotalXfers = 3 + 14 + 17 + 4 + 8;
  localparam int IdleCycles = 7;
  localparam int TestCycles = ResetCycles + IdleCycles + TotalXfers * XferCycles;

  logic                  HCLK;
  logic                  HRESETn;
  logic                  HSEL;
  ahbRamPkg::addrT       HADDR;
  logic                  HWRITE;
  ahbRamPkg::transT      HTRANS;
  ahbRamPkg::sizeT       HSIZE;
  logic [DataWidth-1:0]  HWDATA;
  logic                  HREADY;
  logic [DataWidth-1:0]  HRDATA;
  logic                  HREADYOUT;

  integer                seed;
  // Byte-wide reference copy of the RAM contents
  logic [7:0]            modelBytes [MemBytes];
  ahbRamPkg::addrT       wordAddrs [6];

  // Pending transfers for runOps, one entry per transfer
  bit                    opWrite [$];
  ahbRamPkg::addrT       opAddr [$];
  ahbRamPkg::sizeT       opSize [$];
  logic [DataWidth-1:0]  opData [$];

  // Single slave, so the bus ready is the slave's own ready
  assign HREADY = HREADYOUT;

  ahbRamTop #(
    .DataWidth  (DataWidth),
    .MemWords   (MemWords),
    .WaitStates (WaitStates)
  ) i_ahbRamTop (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWRITE    (HWRITE),
    .HTRANS    (HTRANS),
    .HSIZE     (HSIZE),
    .HWDATA    (HWDATA),
    .HREADY    (HREADY),
    .HRDATA    (HRDATA),
    .HREADYOUT (HREADYOUT)
  );

  initial begin
    HCLK = 1'b0;
  end

  always #(ClkPeriod / 2) HCLK = ~HCLK;

  //////////////////////////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////////////////////////

  task automatic stopRun();
    $display("Test failures found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic checkValue(input string testName, input logic [DataWidth-1:0] expected,
                            input logic [DataWidth-1:0] actual);
    if (actual !== expected) begin
      $display("Error in %s: expected %h, actual %h", testName, expected, actual);
      stopRun();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Index of lane 0 of the addressed word, wrapping at the memory size
  function automatic int wordBase(input ahbRamPkg::addrT addr);
    return ((addr / BytesPerWord) % MemWords) * BytesPerWord;
  endfunction

  // Sizes of a word or more fill every lane, smaller ones align down
  task automatic modelWrite(input ahbRamPkg::addrT addr, input ahbRamPkg::sizeT size,
                            input logic [DataWidth-1:0] data);
    int numBytes;
    int first;
    int base;
    base = wordBase(addr);
    numBytes = (size >= WordSizeCode) ? BytesPerWord : (1 << size);
    first = ((addr % BytesPerWord) / numBytes) * numBytes;
    for (int b = first; b < first + numBytes; b++) begin
      modelBytes[base + b] = data[8*b +: 8];
    end
  endtask

  function automatic logic [DataWidth-1:0] modelRead(input ahbRamPkg::addrT addr);
    logic [DataWidth-1:0] word;
    int base;
    base = wordBase(addr);
    for (int b = 0; b < BytesPerWord; b++) begin
      word[8*b +: 8] = modelBytes[base + b];
    end
    return word;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic addOp(input bit isWrite, input ahbRamPkg::addrT addr,
                       input ahbRamPkg::sizeT size, input logic [DataWidth-1:0] data);
    opWrite.push_back(isWrite);
    opAddr.push_back(addr);
    opSize.push_back(size);
    opData.push_back(data);
  endtask

  task automatic busWrite(input ahbRamPkg::addrT addr, input ahbRamPkg::sizeT size,
                          input logic [DataWidth-1:0] data);
    addOp(1'b1, addr, size, data);
  endtask

  task automatic busRead(input ahbRamPkg::addrT addr);
    addOp(1'b0, addr, ahbRamPkg::SizeWord, '0);
  endtask

  task automatic driveAddress(input int i, input ahbRamPkg::transT trans);
    HSEL   = 1'b1;
    HTRANS = trans;
    HADDR  = opAddr[i];
    HWRITE = opWrite[i];
    HSIZE  = opSize[i];
  endtask

  task automatic driveIdle();
    HSEL   = 1'b0;
    HTRANS = ahbRamPkg::TransIdle;
    HADDR  = ahbRamPkg::addrT'($random(seed));
    HWRITE = 1'b0;
    HSIZE  = ahbRamPkg::SizeWord;
  endtask

  // Runs the queued transfers, either single or with each next address phase
  // overlapping the ending cycle of the current one
  // Called and left on a falling edge
  task automatic runOps(input string testName, input bit pipelined);
    int lowCycles;
    for (int i = 0; i < opWrite.size(); i++) begin
      if (!pipelined || i == 0) begin
        driveAddress(i, ahbRamPkg::TransNonseq);
        @(posedge HCLK);
        @(negedge HCLK);
      end
      // Data phase, write data comes one cycle after its address
      HWDATA = opWrite[i] ? opData[i] : DataWidth'($random(seed));
      if (pipelined && i + 1 < opWrite.size()) begin
        driveAddress(i + 1, ahbRamPkg::TransSeq);
      end else begin
        driveIdle();
      end
      lowCycles = 0;
      while (HREADYOUT !== 1'b1) begin
        lowCycles++;
        if (lowCycles > MaxWait) begin
          $display("HREADYOUT stayed low too long in test %s", testName);
          stopRun();
        end
        @(negedge HCLK);
      end
      checkValue({testName, " wait cycles"}, WaitStates + 1, lowCycles);
      if (opWrite[i]) begin
        modelWrite(opAddr[i], opSize[i], opData[i]);
      end else begin
        checkValue({testName, " read data"}, modelRead(opAddr[i]), HRDATA);
      end
      @(posedge HCLK);
      @(negedge HCLK);
    end
    opWrite.delete();
    opAddr.delete();
    opSize.delete();
    opData.delete();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic testReset();
    logic [DataWidth-1:0] data;
    checkValue("reset ready", 1, HREADYOUT);
    data = $random(seed);
    busWrite(32'h40, ahbRamPkg::SizeWord, data);
    busRead(32'h40);
    runOps("reset", 1'b0);
    // Unselected and IDLE or BUSY phases must neither start nor write anything
    for (int c = 0; c < IdleCycles; c++) begin
      HSEL   = (c >= 3);
      HTRANS = (c < 3) ? ahbRamPkg::TransNonseq :
               (c[0] ? ahbRamPkg::TransBusy : ahbRamPkg::TransIdle);
      HWRITE = 1'b1;
      HADDR  = 32'h40;
      HWDATA = ~data;
      @(negedge HCLK);
      checkValue("reset idle ready", 1, HREADYOUT);
      checkValue("reset idle hold", modelRead(32'h40), HRDATA);
    end
    busRead(32'h40);
    runOps("reset", 1'b0);
  endtask

  task automatic testWordAccess();
    for (int i = 0; i < 6; i++) begin
      wordAddrs[i] = ahbRamPkg::addrT'($random(seed)) &
                     ahbRamPkg::addrT'(MemBytes - BytesPerWord);
      busWrite(wordAddrs[i], ahbRamPkg::SizeWord, DataWidth'($random(seed)));
    end
    for (int i = 0; i < 6; i++) begin
      busRead(wordAddrs[i]);
    end
    // Five memory sizes higher lands on the same word
    busWrite(wordAddrs[0] + 5 * MemBytes, ahbRamPkg::SizeWord, DataWidth'($random(seed)));
    busRead(wordAddrs[0]);
    runOps("word access", 1'b0);
  endtask

  task automatic testSubWord();
    busWrite(32'h100, ahbRamPkg::SizeWord, DataWidth'($random(seed)));
    for (int off = 0; off < BytesPerWord; off++) begin
      busWrite(32'h100 + off, ahbRamPkg::SizeByte, DataWidth'($random(seed)));
      busRead(32'h100);
    end
    // Odd offsets must align down to the halfword
    for (int off = 0; off < BytesPerWord; off++) begin
      busWrite(32'h100 + off, ahbRamPkg::SizeHalf, DataWidth'($random(seed)));
      busRead(32'h100);
    end
    runOps("sub-word", 1'b0);
  endtask

  task automatic testWaitTiming();
    // A doubleword on a 32-bit bus still writes the whole word
    busWrite(32'h3f8, ahbRamPkg::SizeDouble, DataWidth'($random(seed)));
    busRead(32'h3f8);
    busWrite(MemBytes - BytesPerWord, ahbRamPkg::SizeWord, DataWidth'($random(seed)));
    busRead(MemBytes - BytesPerWord);
    runOps("wait timing", 1'b0);
  endtask

  task automatic testPipeline();
    busWrite(wordAddrs[1], ahbRamPkg::SizeWord, DataWidth'($random(seed)));
    busRead(wordAddrs[1]);
    busWrite(wordAddrs[2] + 1, ahbRamPkg::SizeByte, DataWidth'($random(seed)));
    busRead(wordAddrs[2]);
    busWrite(wordAddrs[3] + 2, ahbRamPkg::SizeHalf, DataWidth'($random(seed)));
    busWrite(wordAddrs[1] + 3, ahbRamPkg::SizeByte, DataWidth'($random(seed)));
    busRead(wordAddrs[3]);
    busRead(wordAddrs[1]);
    runOps("pipeline", 1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed       = 32'h2c430fbd;
    HRESETn    = 1'b0;
    HSEL       = 1'b0;
    HADDR      = '0;
    HWRITE     = 1'b0;
    HTRANS     = ahbRamPkg::TransIdle;
    HSIZE      = ahbRamPkg::SizeWord;
    HWDATA     = '0;
    repeat (ResetCycles) @(negedge HCLK);
    HRESETn = 1'b1;
    @(negedge HCLK);
    testReset();
    testWordAccess();
    testSubWord();
    testWaitTiming();
    testPipeline();
    $display("All tests passed!");
    $finish;
  end

  initial begin
    #(TestCycles * 2 * ClkPeriod);
    $display("Timeout: the tests did not finish within %0d clock cycles", TestCycles * 2);
    stopRun();
  end

endmodule
